// File: verilog.f
common/apb_pkg.sv
common/gpio_pkg.sv
gpio/gpio_apb_ctrl.sv
gpio/gpio_regfile.sv
gpio/gpio_pin_io.sv
source/gpio_top.sv
verif/gpio_sva.sv
verif/gpio_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module gpio_tb \
    -f verilog.f -Mdir obj_dir -o gpio_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/gpio_sim > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

// File: verif/gpio_tb.sv
`timescale 1ns/1ps

module gpio_tb;

    localparam int AW = apb_pkg::DEF_ADDR_WIDTH;
    localparam int DW = apb_pkg::DEF_DATA_WIDTH;
    localparam int GW = gpio_pkg::DEF_GPIO_WIDTH;
    localparam int SW = DW / apb_pkg::BYTE_BITS;
    localparam int LB = $clog2(SW);
    localparam int FB = gpio_pkg::FUNC_BITS;
    localparam logic [DW-1:0] PIN_MASK = {DW{1'b1}} >> (DW - GW);

    localparam int N_WR    = 40;
    localparam int N_PIN   = 8;
    localparam int N_BAD   = 8;
    localparam int N_PAUSE = 4;
    // Readbacks add 18 transfers, idle gaps are counted as transfers
    localparam int N_XFER      = 2 * N_WR + 4 * N_PIN + 2 * N_BAD + 12 * N_PAUSE + 18;
    localparam int CYCLE_LIMIT = 4 * N_XFER * 3 + 5;

    logic                 clk = 1'b0;
    logic                 rst;
    logic [AW-1:0]        paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [DW-1:0]        pwdata;
    logic [SW-1:0]        pstrb;
    logic                 pready;
    logic [DW-1:0]        prdata;
    logic                 pslverr;
    logic                 pause_req;
    logic                 pause_ack;
    logic                 irq;
    logic [GW-1:0]        pin_in;
    logic [GW-1:0]        pin_out;
    logic [GW-1:0]        pin_oe;
    logic [GW*FB-1:0]     func;

    logic [31:0]   lfsr = 32'h25bfa703;
    int            cycles = 0;
    logic [DW-1:0] shadow [0:6];   // Model copy of the register words
    logic [GW-1:0] sync1;
    logic [GW-1:0] sync2;          // Model of idr
    logic          in_pause;

    gpio_top #(
        .ADDR_WIDTH (AW),
        .DATA_WIDTH (DW),
        .GPIO_WIDTH (GW)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq),
        .pin_in    (pin_in),
        .pin_out   (pin_out),
        .pin_oe    (pin_oe),
        .func      (func)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    // Two-stage input model
    always @(posedge clk) begin
        if (rst) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= pin_in;
            sync2 <= sync1;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [AW-1:0] word,
                            input logic [DW-1:0] wdata, input logic [SW-1:0] strb,
                            output logic [DW-1:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;                // Setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= word << LB;
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        do begin
            @(negedge clk);
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [AW-1:0] word, input logic [DW-1:0] wdata,
                             input logic [SW-1:0] strb, output logic err);
        logic [DW-1:0] unused_rd;
        apb_xfer(1'b1, word, wdata, strb, unused_rd, err);
    endtask

    task automatic apb_read(input logic [AW-1:0] word, output logic [DW-1:0] rdata,
                            output logic err);
        apb_xfer(1'b0, word, '0, '0, rdata, err);
    endtask

    task automatic model_write(input int word, input logic [DW-1:0] wdata,
                               input logic [SW-1:0] strb);
        logic [DW-1:0] mask;
        for (int i = 0; i < SW; i++) begin
            mask[i*apb_pkg::BYTE_BITS +: apb_pkg::BYTE_BITS] = {apb_pkg::BYTE_BITS{strb[i]}};
        end
        shadow[word] = (wdata & mask) | (shadow[word] & ~mask);
        if (word != gpio_pkg::REG_FSR0 && word != gpio_pkg::REG_FSR1) begin
            shadow[word] = shadow[word] & PIN_MASK;   // Pin registers are GW wide
        end
    endtask

    task automatic check_outputs();
        logic [GW-1:0]    odr_m;
        logic [GW-1:0]    mode_m;
        logic [GW-1:0]    otype_m;
        logic [GW-1:0]    ier_m;
        logic [GW-1:0]    exp_oe;
        logic [GW*FB-1:0] exp_func;
        logic [2*DW-1:0]  fsr_cat;
        logic             exp_irq;
        odr_m   = shadow[gpio_pkg::REG_ODR][GW-1:0];
        mode_m  = shadow[gpio_pkg::REG_MODER][GW-1:0];
        otype_m = shadow[gpio_pkg::REG_OTYPER][GW-1:0];
        ier_m   = shadow[gpio_pkg::REG_IER][GW-1:0];
        fsr_cat = {shadow[gpio_pkg::REG_FSR1], shadow[gpio_pkg::REG_FSR0]};
        for (int i = 0; i < GW; i++) begin
            exp_oe[i] = (mode_m[i] == gpio_pkg::MODE_OUTPUT);
            if (otype_m[i] == gpio_pkg::OTYPE_OPEN_DRAIN && odr_m[i]) begin
                exp_oe[i] = 1'b0;       // Open drain releases a high pin
            end
            exp_func[i*FB +: FB] = {fsr_cat[2*i+1], fsr_cat[2*i]};
        end
        exp_irq = !in_pause && |(ier_m & sync2);
        expect_eq(pin_out, odr_m, "pin_out");
        expect_eq(pin_oe, exp_oe, "pin_oe");
        expect_eq(func, exp_func, "func");
        expect_eq(irq, exp_irq, "irq");
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            check_outputs();
        end
    endtask

    task automatic readback_all();
        logic [DW-1:0] rd;
        logic          err;
        for (int w = gpio_pkg::REG_ODR; w <= gpio_pkg::REG_IER; w++) begin
            apb_read(w, rd, err);
            expect_eq(err, 0, "pslverr on readback");
            expect_eq(rd, shadow[w], "readback data");
        end
    endtask

    initial begin
        logic [DW-1:0] rd;
        logic [DW-1:0] wd;
        logic [SW-1:0] st;
        logic [AW-1:0] w;
        logic [GW-1:0] pv;
        logic          wr;
        logic          err;
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pstrb     = '0;
        pause_req = 1'b0;
        pin_in    = '0;
        in_pause  = 1'b0;
        for (int i = 0; i <= gpio_pkg::REG_IER; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        idle(2);
        expect_eq(pready, 0, "pready after reset");
        expect_eq(pause_ack, 0, "pause_ack after reset");

        // Strobed writes to the writable words
        for (int i = 0; i < N_WR; i++) begin
            w  = 1 + rand_bits(3) % 6;
            wd = rand_bits(DW);
            st = rand_bits(SW);
            apb_write(w, wd, st, err);
            expect_eq(err, 0, "pslverr on write");
            model_write(w, wd, st);
            idle(1);
            apb_read(w, rd, err);
            expect_eq(err, 0, "pslverr on read");
            expect_eq(rd, shadow[w], "read after write");
        end
        readback_all();

        // Input sampling and the read-only word
        for (int i = 0; i < N_PIN; i++) begin
            pv = rand_bits(GW);
            @(posedge clk);
            pin_in <= pv;
            idle(3);
            apb_read(gpio_pkg::REG_IDR, rd, err);
            expect_eq(err, 0, "pslverr on input read");
            expect_eq(rd, pv, "input data");
            wd = rand_bits(DW);
            st = rand_bits(SW);
            apb_write(gpio_pkg::REG_IDR, wd, st, err);
            expect_eq(err, 1, "pslverr on input data write");
            apb_read(gpio_pkg::REG_IDR, rd, err);
            expect_eq(rd, pv, "input data after write");
        end
        readback_all();

        // Unmapped words
        for (int i = 0; i < N_BAD; i++) begin
            w = 7 + rand_bits(8);
            apb_read(w, rd, err);
            expect_eq(err, 1, "pslverr on unmapped read");
            expect_eq(rd, 0, "prdata on unmapped read");
            wd = rand_bits(DW);
            st = rand_bits(SW);
            apb_write(w, wd, st, err);
            expect_eq(err, 1, "pslverr on unmapped write");
            idle(1);
        end
        readback_all();

        // Pause handshake
        for (int i = 0; i < N_PAUSE; i++) begin
            idle(rand_bits(3));
            if (i % 2 == 0) begin
                @(posedge clk);
                pause_req <= 1'b1;
            end else begin
                // Request arrives with a read setup, the read is served first
                w = 1 + rand_bits(3) % 6;
                fork
                    apb_read(w, rd, err);
                    begin
                        @(posedge clk);
                        pause_req <= 1'b1;
                    end
                join
                expect_eq(err, 0, "pslverr on read meeting the pause request");
                expect_eq(rd, shadow[w], "read meeting the pause request");
            end
            do begin
                @(negedge clk);
            end while (!pause_ack);
            in_pause = 1'b1;
            check_outputs();
            for (int j = 0; j < 3; j++) begin
                w  = 1 + rand_bits(3) % 6;
                wr = (rand_bits(1) != 0);
                wd = rand_bits(DW);
                st = rand_bits(SW);
                apb_xfer(wr, w, wd, st, rd, err);
                expect_eq(err, 1, "pslverr while paused");
                expect_eq(rd, 0, "prdata while paused");
                idle(1);
            end
            @(posedge clk);
            pause_req <= 1'b0;
            do begin
                @(negedge clk);
            end while (pause_ack);
            in_pause = 1'b0;
            readback_all();
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: verif/gpio_sva.sv
`timescale 1ns/1ps

module gpio_sva (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pause_req,
    input logic pause_ack,
    input logic frozen,
    input logic irq
);

    // Ack only answers a request
    ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(pause_ack) |-> $past(pause_req))
        else $error("pause_ack rose while pause_req was low");

    ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(pause_ack) |-> !$past(pause_req))
        else $error("pause_ack fell while pause_req was still high");

    // Completion outside a pause clears pready
    ready_drop: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pready && !pause_ack) |=> !pready)
        else $error("pready stayed high after a completed transfer");

    irq_frozen: assert property (@(posedge clk) disable iff (rst)
        frozen |-> !irq)
        else $error("irq high while the block is frozen");

endmodule

bind gpio_top gpio_sva sva0 (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pause_req (pause_req),
    .pause_ack (pause_ack),
    .frozen    (frozen),
    .irq       (irq)
);

// File: source/gpio_top.sv
`timescale 1ns/1ps

module gpio_top #(
    parameter int ADDR_WIDTH = apb_pkg::DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH = apb_pkg::DEF_DATA_WIDTH,
    parameter int GPIO_WIDTH = gpio_pkg::DEF_GPIO_WIDTH,
    localparam int STRB_WIDTH = DATA_WIDTH / apb_pkg::BYTE_BITS
) (
    input  logic                                   clk,
    input  logic                                   rst,

    input  logic [ADDR_WIDTH-1:0]                  paddr,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [DATA_WIDTH-1:0]                  pwdata,
    input  logic [STRB_WIDTH-1:0]                  pstrb,
    output logic                                   pready,
    output logic [DATA_WIDTH-1:0]                  prdata,
    output logic                                   pslverr,

    input  logic                                   pause_req,
    output logic                                   pause_ack,

    output logic                                   irq,

    input  logic [GPIO_WIDTH-1:0]                  pin_in,
    output logic [GPIO_WIDTH-1:0]                  pin_out,
    output logic [GPIO_WIDTH-1:0]                  pin_oe,
    output logic [GPIO_WIDTH*gpio_pkg::FUNC_BITS-1:0] func
);

    // Controller to register file
    logic                             reg_wr;
    logic [gpio_pkg::REG_IDX_BITS-1:0] reg_idx;
    logic [DATA_WIDTH-1:0]            wr_mask;
    logic [DATA_WIDTH-1:0]            wr_data;
    logic [DATA_WIDTH-1:0]            rd_data;
    logic                             frozen;

    // Register contents toward the pins
    logic [GPIO_WIDTH-1:0] idr;
    logic [GPIO_WIDTH-1:0] odr;
    logic [GPIO_WIDTH-1:0] moder;
    logic [GPIO_WIDTH-1:0] otyper;
    logic [DATA_WIDTH-1:0] fsr0;
    logic [DATA_WIDTH-1:0] fsr1;
    logic [GPIO_WIDTH-1:0] ier;

    gpio_apb_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .rd_data   (rd_data),
        .reg_wr    (reg_wr),
        .reg_idx   (reg_idx),
        .wr_mask   (wr_mask),
        .wr_data   (wr_data),
        .frozen    (frozen)
    );

    gpio_regfile #(
        .DATA_WIDTH (DATA_WIDTH),
        .GPIO_WIDTH (GPIO_WIDTH)
    ) u_regs (
        .clk     (clk),
        .rst     (rst),
        .reg_wr  (reg_wr),
        .reg_idx (reg_idx),
        .wr_mask (wr_mask),
        .wr_data (wr_data),
        .idr     (idr),
        .rd_data (rd_data),
        .odr     (odr),
        .moder   (moder),
        .otyper  (otyper),
        .fsr0    (fsr0),
        .fsr1    (fsr1),
        .ier     (ier)
    );

    gpio_pin_io #(
        .DATA_WIDTH (DATA_WIDTH),
        .GPIO_WIDTH (GPIO_WIDTH)
    ) u_pins (
        .clk     (clk),
        .rst     (rst),
        .pin_in  (pin_in),
        .odr     (odr),
        .moder   (moder),
        .otyper  (otyper),
        .fsr0    (fsr0),
        .fsr1    (fsr1),
        .ier     (ier),
        .frozen  (frozen),
        .idr     (idr),
        .pin_out (pin_out),
        .pin_oe  (pin_oe),
        .func    (func),
        .irq     (irq)
    );

endmodule

// File: gpio/gpio_pin_io.sv
`timescale 1ns/1ps

module gpio_pin_io #(
    parameter int DATA_WIDTH = 32,
    parameter int GPIO_WIDTH = 16
) (
    input  logic                                      clk,
    input  logic                                      rst,

    input  logic [GPIO_WIDTH-1:0]                     pin_in,
    input  logic [GPIO_WIDTH-1:0]                     odr,
    input  logic [GPIO_WIDTH-1:0]                     moder,
    input  logic [GPIO_WIDTH-1:0]                     otyper,
    input  logic [DATA_WIDTH-1:0]                     fsr0,
    input  logic [DATA_WIDTH-1:0]                     fsr1,
    input  logic [GPIO_WIDTH-1:0]                     ier,
    input  logic                                      frozen,

    output logic [GPIO_WIDTH-1:0]                     idr,
    output logic [GPIO_WIDTH-1:0]                     pin_out,
    output logic [GPIO_WIDTH-1:0]                     pin_oe,
    output logic [GPIO_WIDTH*gpio_pkg::FUNC_BITS-1:0] func,
    output logic                                      irq
);

    localparam int FB = gpio_pkg::FUNC_BITS;

    logic [GPIO_WIDTH-1:0]   sync_q;   // First synchroniser stage
    logic [2*DATA_WIDTH-1:0] fsr_all;

    // Two-flop synchroniser, idr is pin_in two edges late
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= '0;
            idr    <= '0;
        end else begin
            sync_q <= pin_in;
            idr    <= sync_q;
        end
    end

    assign pin_out = odr;

    // Open-drain only drives the low level
    always_comb begin
        for (int i = 0; i < GPIO_WIDTH; i++) begin
            pin_oe[i] = 1'b0;
            if (moder[i] == gpio_pkg::MODE_OUTPUT) begin
                case (otyper[i])
                    gpio_pkg::OTYPE_PUSH_PULL:  pin_oe[i] = 1'b1;
                    gpio_pkg::OTYPE_OPEN_DRAIN: pin_oe[i] = ~odr[i];
                endcase
            end
        end
    end

    // Pin i takes bits 2i and 2i+1 of the two select words
    assign fsr_all = {fsr1, fsr0};

    always_comb begin
        for (int i = 0; i < GPIO_WIDTH; i++) begin
            func[i*FB +: FB] = fsr_all[i*FB +: FB];
        end
    end

    assign irq = frozen ? 1'b0 : |(ier & idr);   // Level, held low in pause

endmodule

// File: gpio/gpio_regfile.sv
`timescale 1ns/1ps

module gpio_regfile #(
    parameter int DATA_WIDTH = 32,
    parameter int GPIO_WIDTH = 16
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              reg_wr,
    input  logic [gpio_pkg::REG_IDX_BITS-1:0] reg_idx,
    input  logic [DATA_WIDTH-1:0]             wr_mask,
    input  logic [DATA_WIDTH-1:0]             wr_data,
    input  logic [GPIO_WIDTH-1:0]             idr,

    output logic [DATA_WIDTH-1:0]             rd_data,
    output logic [GPIO_WIDTH-1:0]             odr,
    output logic [GPIO_WIDTH-1:0]             moder,
    output logic [GPIO_WIDTH-1:0]             otyper,
    output logic [DATA_WIDTH-1:0]             fsr0,
    output logic [DATA_WIDTH-1:0]             fsr1,
    output logic [GPIO_WIDTH-1:0]             ier
);

    // Per-pin registers only see the low lanes of the bus
    logic [GPIO_WIDTH-1:0] pin_data;
    logic [GPIO_WIDTH-1:0] pin_mask;

    assign pin_data = wr_data[GPIO_WIDTH-1:0];
    assign pin_mask = wr_mask[GPIO_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            odr    <= '0;
            moder  <= '0;
            otyper <= '0;
            fsr0   <= '0;
            fsr1   <= '0;
            ier    <= '0;
        end else if (reg_wr) begin
            // Keep bits whose strobe lane is off
            case (reg_idx)
                gpio_pkg::REG_ODR:    odr    <= (pin_data & pin_mask) | (odr & ~pin_mask);
                gpio_pkg::REG_MODER:  moder  <= (pin_data & pin_mask) | (moder & ~pin_mask);
                gpio_pkg::REG_OTYPER: otyper <= (pin_data & pin_mask) | (otyper & ~pin_mask);
                gpio_pkg::REG_FSR0:   fsr0   <= (wr_data & wr_mask) | (fsr0 & ~wr_mask);
                gpio_pkg::REG_FSR1:   fsr1   <= (wr_data & wr_mask) | (fsr1 & ~wr_mask);
                gpio_pkg::REG_IER:    ier    <= (pin_data & pin_mask) | (ier & ~pin_mask);
                default: begin
                    // Input register and unmapped words hold nothing here
                end
            endcase
        end
    end

    // Read mux, zero-extended pin registers
    always_comb begin
        rd_data = '0;
        case (reg_idx)
            gpio_pkg::REG_IDR:    rd_data[GPIO_WIDTH-1:0] = idr;
            gpio_pkg::REG_ODR:    rd_data[GPIO_WIDTH-1:0] = odr;
            gpio_pkg::REG_MODER:  rd_data[GPIO_WIDTH-1:0] = moder;
            gpio_pkg::REG_OTYPER: rd_data[GPIO_WIDTH-1:0] = otyper;
            gpio_pkg::REG_FSR0:   rd_data = fsr0;
            gpio_pkg::REG_FSR1:   rd_data = fsr1;
            gpio_pkg::REG_IER:    rd_data[GPIO_WIDTH-1:0] = ier;
            default:              rd_data = '0;
        endcase
    end

endmodule

// File: gpio/gpio_apb_ctrl.sv
`timescale 1ns/1ps

module gpio_apb_ctrl #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32,
    localparam int STRB_WIDTH = DATA_WIDTH / apb_pkg::BYTE_BITS
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [ADDR_WIDTH-1:0]             paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [DATA_WIDTH-1:0]             pwdata,
    input  logic [STRB_WIDTH-1:0]             pstrb,
    output logic                              pready,
    output logic [DATA_WIDTH-1:0]             prdata,
    output logic                              pslverr,

    input  logic                              pause_req,
    output logic                              pause_ack,

    input  logic [DATA_WIDTH-1:0]             rd_data,
    output logic                              reg_wr,
    output logic [gpio_pkg::REG_IDX_BITS-1:0] reg_idx,
    output logic [DATA_WIDTH-1:0]             wr_mask,
    output logic [DATA_WIDTH-1:0]             wr_data,
    output logic                              frozen
);

    // Word index sits above the byte-lane bits of paddr
    localparam int LANE_BITS = $clog2(STRB_WIDTH);
    localparam int IDX_WIDTH = ADDR_WIDTH - LANE_BITS;

    logic [IDX_WIDTH-1:0] word_idx;
    logic                 mapped;
    logic                 read_only;
    logic                 accept;
    logic                 complete;
    logic                 bad_access;

    assign word_idx  = paddr[ADDR_WIDTH-1:LANE_BITS];
    assign mapped    = (word_idx <= gpio_pkg::REG_IER);
    assign read_only = (word_idx == gpio_pkg::REG_IDR);
    assign reg_idx   = word_idx[gpio_pkg::REG_IDX_BITS-1:0];

    // Error on unmapped word or a write to the input register
    assign bad_access = !mapped || (pwrite && read_only);

    // New transfer seen in setup or access phase, not yet answered
    assign accept   = psel && !pready;
    // Access phase meets our pready, only outside a pause
    assign complete = psel && penable && pready && !pause_ack;

    assign frozen = pause_req && pause_ack;

    // Strobe lanes widened to a bit mask
    always_comb begin
        for (int i = 0; i < STRB_WIDTH; i++) begin
            wr_mask[i*apb_pkg::BYTE_BITS +: apb_pkg::BYTE_BITS] =
                {apb_pkg::BYTE_BITS{pstrb[i]}};
        end
    end

    assign wr_data = pwdata;

    // Register write lands on the same edge that raises pready
    assign reg_wr = accept && pwrite && !bad_access;

    // pause_ack is the whole pause state; frozen matches no branch below
    always_ff @(posedge clk) begin
        if (rst) begin
            pready    <= 1'b0;
            prdata    <= '0;
            pslverr   <= 1'b0;
            pause_ack <= 1'b0;
        end else if (accept) begin
            pready <= 1'b1;
            if (bad_access) begin
                pslverr <= 1'b1;    // prdata stays zero
            end else if (!pwrite) begin
                prdata <= rd_data;
            end
        end else if (complete) begin
            pready  <= 1'b0;
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (pause_req && !pause_ack) begin
            // Enter pause, anything in flight ends with an error
            pause_ack <= 1'b1;
            pready    <= 1'b1;
            pslverr   <= 1'b1;
            prdata    <= '0;
        end else if (!pause_req && pause_ack) begin
            // Resume
            pause_ack <= 1'b0;
            pready    <= 1'b0;
            pslverr   <= 1'b0;
            prdata    <= '0;
        end
    end

endmodule

// File: common/gpio_pkg.sv
package gpio_pkg;

    // Word index of each register, address bits above the strobe lanes
    localparam int REG_IDR    = 0;  // Input data, read-only
    localparam int REG_ODR    = 1;  // Output data
    localparam int REG_MODER  = 2;  // Pin direction
    localparam int REG_OTYPER = 3;  // Push-pull or open-drain
    localparam int REG_FSR0   = 4;  // Function select, pins 0 to DATA_WIDTH/2-1
    localparam int REG_FSR1   = 5;  // Function select, upper pins
    localparam int REG_IER    = 6;  // Interrupt enable

    localparam int REG_IDX_BITS = 3;

    // One mode bit per pin
    localparam logic MODE_INPUT  = 1'b0;
    localparam logic MODE_OUTPUT = 1'b1;

    // One output-type bit per pin
    localparam logic OTYPE_PUSH_PULL  = 1'b0;
    localparam logic OTYPE_OPEN_DRAIN = 1'b1;

    // Two select words hold two bits per pin
    localparam int FUNC_BITS = 2;

    localparam int DEF_GPIO_WIDTH = 16;

endpackage

// File: common/apb_pkg.sv
package apb_pkg;

    // Default bus geometry, overridable from the top level
    localparam int DEF_ADDR_WIDTH = 32;
    localparam int DEF_DATA_WIDTH = 32;

    // Bits covered by one pstrb lane
    localparam int BYTE_BITS = 8;

endpackage
